// File: include/ms_macros.svh
// memory stage macros: datapath widths, data SRAM size and write-back credit count
`ifndef MS_MACROS_SVH
`define MS_MACROS_SVH

// one RV64 word, also the address width
`define MS_WORD_WD      64

`define MS_GPR_ADDR_WD  5   // x0..x31
`define MS_CSR_ADDR_WD  12

// data sram holds doublewords, index taken from address bits 10:3
`define MS_SRAM_DEPTH   256
`define MS_SRAM_AW      8

// write-back buffer depth seen as credits
`define MS_WS_CREDITS   4
`define MS_CREDIT_WD    3   // must hold MS_WS_CREDITS

`endif

// File: design/ms_pkg.sv
// memory stage package: memory op codes and controller state encoding
package ms_pkg;

  // funct3 encoding of the memory op
  typedef enum logic [2:0] {
    MEM_LB  = 3'd0,
    MEM_LH  = 3'd1,
    MEM_LW  = 3'd2,
    MEM_LD  = 3'd3,
    MEM_LBU = 3'd4,
    MEM_LHU = 3'd5,
    MEM_LWU = 3'd6
  } mem_op_e;

  // stores reuse codes 0..3
  localparam mem_op_e MEM_SB = MEM_LB;
  localparam mem_op_e MEM_SH = MEM_LH;
  localparam mem_op_e MEM_SW = MEM_LW;
  localparam mem_op_e MEM_SD = MEM_LD;

  // access size lives in the low two bits for both loads and stores
  localparam logic [1:0] SIZE_B = 2'd0;
  localparam logic [1:0] SIZE_H = 2'd1;
  localparam logic [1:0] SIZE_W = 2'd2;
  localparam logic [1:0] SIZE_D = 2'd3;

  // memory stage controller
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0, // waiting for execute
    ST_ACCESS = 2'd1, // sram cycle
    ST_RESP   = 2'd2  // result held until a write-back credit is free
  } ms_state_e;

endpackage

// File: design/lsu_load.sv
// load unit: picks the addressed byte, half, word or doubleword and extends it
`timescale 1ns/10ps
`include "ms_macros.svh"

module lsu_load (
  input        [2:0]             i_raddr_align     , // byte offset in the doubleword
  input        [`MS_WORD_WD-1:0] i_data_sram_rdata ,
  input                          i_mem_ren         ,
  input  ms_pkg::mem_op_e        i_mem_op          ,
  output logic [`MS_WORD_WD-1:0] o_rdata
);

  import ms_pkg::*;

  logic [2:0]             byte_off; // offset forced to the access alignment
  logic [`MS_WORD_WD-1:0] shifted;

  // misaligned addresses fall back to the aligned lane
  always_comb begin
    case (i_mem_op[1:0])
      SIZE_B:  byte_off = i_raddr_align;
      SIZE_H:  byte_off = {i_raddr_align[2:1], 1'b0};
      SIZE_W:  byte_off = {i_raddr_align[2], 2'b00};
      default: byte_off = 3'd0;
    endcase
  end

  assign shifted = i_data_sram_rdata >> {byte_off, 3'b000};

  always_comb begin
    if (!i_mem_ren) begin
      o_rdata = '0; // not a load
    end else begin
      case (i_mem_op)
        MEM_LB:  o_rdata = {{(`MS_WORD_WD-8){shifted[7]}}, shifted[7:0]};
        MEM_LH:  o_rdata = {{(`MS_WORD_WD-16){shifted[15]}}, shifted[15:0]};
        MEM_LW:  o_rdata = {{(`MS_WORD_WD-32){shifted[31]}}, shifted[31:0]};
        MEM_LD:  o_rdata = shifted;
        MEM_LBU: o_rdata = {{(`MS_WORD_WD-8){1'b0}}, shifted[7:0]};
        MEM_LHU: o_rdata = {{(`MS_WORD_WD-16){1'b0}}, shifted[15:0]};
        MEM_LWU: o_rdata = {{(`MS_WORD_WD-32){1'b0}}, shifted[31:0]};
        default: o_rdata = '0; // code 7 unused
      endcase
    end
  end

endmodule

// File: design/lsu_store.sv
// store unit: places store data in its byte lanes and builds the write strobes
`timescale 1ns/10ps
`include "ms_macros.svh"

module lsu_store (
  input        [2:0]             i_waddr_align , // byte offset in the doubleword
  input        [`MS_WORD_WD-1:0] i_store_data  ,
  input  ms_pkg::mem_op_e        i_mem_op      ,
  output logic [`MS_WORD_WD-1:0] o_wdata       ,
  output logic [7:0]             o_wstrb
);

  import ms_pkg::*;

  // data is replicated across all lanes, the strobe picks the live one
  always_comb begin
    case (i_mem_op[1:0])
      SIZE_B: begin
        o_wdata = {(`MS_WORD_WD/8){i_store_data[7:0]}};
        o_wstrb = 8'b0000_0001 << i_waddr_align;
      end
      SIZE_H: begin
        o_wdata = {(`MS_WORD_WD/16){i_store_data[15:0]}};
        o_wstrb = 8'b0000_0011 << {i_waddr_align[2:1], 1'b0}; // halfword aligned
      end
      SIZE_W: begin
        o_wdata = {(`MS_WORD_WD/32){i_store_data[31:0]}};
        o_wstrb = 8'b0000_1111 << {i_waddr_align[2], 2'b00};
      end
      default: begin
        o_wdata = i_store_data; // full doubleword
        o_wstrb = 8'hff;
      end
    endcase
  end

endmodule

// File: design/data_sram.sv
// data SRAM: doubleword array, registered read and byte-strobe writes
`timescale 1ns/10ps
`include "ms_macros.svh"

module data_sram (
  input                          i_clk   ,
  input                          i_en    ,
  input                          i_wen   ,
  input        [`MS_SRAM_AW-1:0] i_addr  ,
  input        [`MS_WORD_WD-1:0] i_wdata ,
  input        [7:0]             i_wstrb ,
  output logic [`MS_WORD_WD-1:0] o_rdata
);

  logic [`MS_WORD_WD-1:0] mem [`MS_SRAM_DEPTH];

  // read returns the old contents on a write cycle
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_rdata <= mem[i_addr];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en && i_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wstrb[b]) begin
          mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // the write strobe comes from mem_stage, the enable from the controller
  a_wen_in_access: assert property (
    @(posedge i_clk) i_wen |-> (i_en && (i_wstrb != 8'h00))
  ) else $error("sram write outside an access or with no byte lanes");

endmodule

// File: design/ws_credit_counter.sv
// write-back credit counter: tracks free slots in the write-back buffer
`timescale 1ns/10ps
`include "ms_macros.svh"

module ws_credit_counter (
  input        i_clk     ,
  input        i_rst     ,
  input        i_consume , // result sent to write-back
  input        i_return  , // write-back freed a slot
  output logic o_avail
);

  logic [`MS_CREDIT_WD-1:0] count_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count_q <= `MS_CREDIT_WD'(`MS_WS_CREDITS);
    end else begin
      case ({i_consume, i_return})
        2'b10:   count_q <= count_q - 1'b1;
        2'b01:   count_q <= count_q + 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

  assign o_avail = (count_q != '0);

  // controller must hold results while no credit is left
  a_no_underflow: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_consume |-> (count_q != '0)
  ) else $error("credit consumed at zero");

  // write-back cannot return more than it was given
  a_no_overflow: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_return |-> (count_q != `MS_CREDIT_WD'(`MS_WS_CREDITS))
  ) else $error("credit returned with counter full");

endmodule

// File: design/ms_ctrl.sv
// memory stage controller sequencing accept, the optional SRAM access and the credit-gated result
`timescale 1ns/10ps

module ms_ctrl (
  input        i_clk          ,
  input        i_rst          ,
  input        i_es_valid     ,
  input        i_mem_access   , // load or store in the instruction register
  input        i_credit_avail ,
  output logic o_capture      ,
  output logic o_sram_en      ,
  output logic o_ws_valid     ,
  output logic o_es_credit
);

  import ms_pkg::*;

  ms_state_e state_q;
  ms_state_e state_nxt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE: begin
        if (i_es_valid) begin
          state_nxt = i_mem_access ? ST_ACCESS : ST_RESP;
        end
      end
      ST_ACCESS: state_nxt = ST_RESP; // read data back next cycle
      ST_RESP: begin
        if (i_credit_avail) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  assign o_capture   = (state_q == ST_IDLE) && i_es_valid;
  assign o_sram_en   = (state_q == ST_ACCESS);
  assign o_ws_valid  = (state_q == ST_RESP) && i_credit_avail;
  assign o_es_credit = o_ws_valid; // execute credit goes back as the result leaves

  // execute only sends while holding its single credit
  a_es_valid_idle: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_es_valid |-> (state_q == ST_IDLE)
  ) else $error("execute sent while an instruction was in flight");

  // only a latched load or store earns an sram cycle
  a_access_mem: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_sram_en |-> i_mem_access
  ) else $error("sram access for an instruction without a load or store");

endmodule

// File: design/mem_stage.sv
// memory stage datapath: instruction register, SRAM request and result select
`timescale 1ns/10ps
`include "ms_macros.svh"

module mem_stage (
  input                             i_clk             ,
  input                             i_rst             ,
  input                             i_capture         ,
  input                             i_sram_en         ,
  input        [`MS_GPR_ADDR_WD-1:0] i_rd             ,
  input        [`MS_CSR_ADDR_WD-1:0] i_csr            ,
  input                             i_gpr_wen         ,
  input                             i_csr_wen         ,
  input                             i_mem_ren         ,
  input                             i_mem_wen         ,
  input  ms_pkg::mem_op_e           i_mem_op          ,
  input                             i_csr_inst_sel    , // csr read data goes to rd
  input        [`MS_WORD_WD-1:0]    i_csrrdata        ,
  input        [`MS_WORD_WD-1:0]    i_alu_result      ,
  input        [`MS_WORD_WD-1:0]    i_csr_result      ,
  input        [`MS_WORD_WD-1:0]    i_store_data      ,
  input        [`MS_WORD_WD-1:0]    i_data_sram_rdata ,
  output logic                      o_mem_access      ,
  output logic [`MS_SRAM_AW-1:0]    o_sram_addr       ,
  output logic [`MS_WORD_WD-1:0]    o_sram_wdata      ,
  output logic [7:0]                o_sram_wstrb      ,
  output logic                      o_sram_wen        ,
  output logic                      o_ws_gpr_wen      ,
  output logic [`MS_GPR_ADDR_WD-1:0] o_ws_rd          ,
  output logic [`MS_WORD_WD-1:0]    o_ws_gpr_result   ,
  output logic                      o_ws_csr_wen      ,
  output logic [`MS_CSR_ADDR_WD-1:0] o_ws_csr         ,
  output logic [`MS_WORD_WD-1:0]    o_ws_csr_result
);

  import ms_pkg::*;

  logic                       gpr_wen_q, csr_wen_q, mem_ren_q, mem_wen_q;
  logic                       csr_inst_sel_q;
  mem_op_e                    mem_op_q;
  logic [`MS_GPR_ADDR_WD-1:0] rd_q;
  logic [`MS_CSR_ADDR_WD-1:0] csr_q;
  logic [`MS_WORD_WD-1:0]     csrrdata_q, alu_result_q, csr_result_q, store_data_q;
  logic                       rdata_fresh; // sram data arrived this cycle
  logic [`MS_WORD_WD-1:0]     load_data;
  logic [`MS_WORD_WD-1:0]     load_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      {gpr_wen_q, csr_wen_q, mem_ren_q, mem_wen_q} <= '0;
      rdata_fresh <= 1'b0;
    end else begin
      rdata_fresh <= i_sram_en;
      if (i_capture) begin
        {gpr_wen_q, csr_wen_q, mem_ren_q, mem_wen_q} <=
          {i_gpr_wen, i_csr_wen, i_mem_ren, i_mem_wen};
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_capture) begin
      rd_q           <= i_rd;
      csr_q          <= i_csr;
      mem_op_q       <= i_mem_op;
      csr_inst_sel_q <= i_csr_inst_sel;
      csrrdata_q     <= i_csrrdata;
      alu_result_q   <= i_alu_result;
      csr_result_q   <= i_csr_result;
      store_data_q   <= i_store_data;
    end
    if (rdata_fresh) begin
      load_q <= load_data; // hold across RESP back-pressure
    end
  end

  // the controller decides ACCESS or RESP in the capture cycle
  assign o_mem_access = i_capture ? (i_mem_ren | i_mem_wen) : (mem_ren_q | mem_wen_q);

  assign o_sram_addr = alu_result_q[10:3];
  assign o_sram_wen  = mem_wen_q & i_sram_en;

  lsu_store u_lsu_store (
    .i_waddr_align (alu_result_q[2:0]),
    .i_store_data  (store_data_q     ),
    .i_mem_op      (mem_op_q         ),
    .o_wdata       (o_sram_wdata     ),
    .o_wstrb       (o_sram_wstrb     )
  );

  lsu_load u_lsu_load (
    .i_raddr_align     (alu_result_q[2:0]),
    .i_data_sram_rdata (i_data_sram_rdata),
    .i_mem_ren         (mem_ren_q        ),
    .i_mem_op          (mem_op_q         ),
    .o_rdata           (load_data        )
  );

  always_comb begin
    if (mem_ren_q) begin
      o_ws_gpr_result = rdata_fresh ? load_data : load_q;
    end else if (csr_inst_sel_q) begin
      o_ws_gpr_result = csrrdata_q;
    end else begin
      o_ws_gpr_result = alu_result_q;
    end
  end

  assign o_ws_gpr_wen    = gpr_wen_q;
  assign o_ws_rd         = rd_q;
  assign o_ws_csr_wen    = csr_wen_q; // csr fields pass straight through
  assign o_ws_csr        = csr_q;
  assign o_ws_csr_result = csr_result_q;

endmodule

// File: design/ms_top.sv
// memory stage top: controller, credit counter, datapath and data SRAM
`timescale 1ns/10ps
`include "ms_macros.svh"

module ms_top (
  input                              i_clk             ,
  input                              i_rst             ,
  // from execute
  input                              i_es_valid        ,
  input        [`MS_GPR_ADDR_WD-1:0] i_es_rd           ,
  input        [`MS_CSR_ADDR_WD-1:0] i_es_csr          ,
  input                              i_es_gpr_wen      ,
  input                              i_es_csr_wen      ,
  input                              i_es_mem_ren      ,
  input                              i_es_mem_wen      ,
  input  ms_pkg::mem_op_e            i_es_mem_op       ,
  input                              i_es_csr_inst_sel ,
  input        [`MS_WORD_WD-1:0]     i_es_csrrdata     ,
  input        [`MS_WORD_WD-1:0]     i_es_alu_result   ,
  input        [`MS_WORD_WD-1:0]     i_es_csr_result   ,
  input        [`MS_WORD_WD-1:0]     i_es_store_data   ,
  output logic                       o_es_credit       ,
  // to write-back
  input                              i_ws_credit       ,
  output logic                       o_ws_valid        ,
  output logic                       o_ws_gpr_wen      ,
  output logic [`MS_GPR_ADDR_WD-1:0] o_ws_rd           ,
  output logic [`MS_WORD_WD-1:0]     o_ws_gpr_result   ,
  output logic                       o_ws_csr_wen      ,
  output logic [`MS_CSR_ADDR_WD-1:0] o_ws_csr          ,
  output logic [`MS_WORD_WD-1:0]     o_ws_csr_result
);

  logic                   capture, sram_en, mem_access, credit_avail;
  logic                   sram_wen;
  logic [`MS_SRAM_AW-1:0] sram_addr;
  logic [`MS_WORD_WD-1:0] sram_wdata, sram_rdata;
  logic [7:0]             sram_wstrb;

  ms_ctrl u_ms_ctrl (
    .i_clk          (i_clk       ),
    .i_rst          (i_rst       ),
    .i_es_valid     (i_es_valid  ),
    .i_mem_access   (mem_access  ),
    .i_credit_avail (credit_avail),
    .o_capture      (capture     ),
    .o_sram_en      (sram_en     ),
    .o_ws_valid     (o_ws_valid  ),
    .o_es_credit    (o_es_credit )
  );

  ws_credit_counter u_ws_credit_counter (
    .i_clk     (i_clk       ),
    .i_rst     (i_rst       ),
    .i_consume (o_ws_valid  ), // each result takes one slot
    .i_return  (i_ws_credit ),
    .o_avail   (credit_avail)
  );

  mem_stage u_mem_stage (
    .i_clk             (i_clk            ),
    .i_rst             (i_rst            ),
    .i_capture         (capture          ),
    .i_sram_en         (sram_en          ),
    .i_rd              (i_es_rd          ),
    .i_csr             (i_es_csr         ),
    .i_gpr_wen         (i_es_gpr_wen     ),
    .i_csr_wen         (i_es_csr_wen     ),
    .i_mem_ren         (i_es_mem_ren     ),
    .i_mem_wen         (i_es_mem_wen     ),
    .i_mem_op          (i_es_mem_op      ),
    .i_csr_inst_sel    (i_es_csr_inst_sel),
    .i_csrrdata        (i_es_csrrdata    ),
    .i_alu_result      (i_es_alu_result  ),
    .i_csr_result      (i_es_csr_result  ),
    .i_store_data      (i_es_store_data  ),
    .i_data_sram_rdata (sram_rdata       ),
    .o_mem_access      (mem_access       ),
    .o_sram_addr       (sram_addr        ),
    .o_sram_wdata      (sram_wdata       ),
    .o_sram_wstrb      (sram_wstrb       ),
    .o_sram_wen        (sram_wen         ),
    .o_ws_gpr_wen      (o_ws_gpr_wen     ),
    .o_ws_rd           (o_ws_rd          ),
    .o_ws_gpr_result   (o_ws_gpr_result  ),
    .o_ws_csr_wen      (o_ws_csr_wen     ),
    .o_ws_csr          (o_ws_csr         ),
    .o_ws_csr_result   (o_ws_csr_result  )
  );

  data_sram u_data_sram (
    .i_clk   (i_clk     ),
    .i_en    (sram_en   ),
    .i_wen   (sram_wen  ),
    .i_addr  (sram_addr ),
    .i_wdata (sram_wdata),
    .i_wstrb (sram_wstrb),
    .o_rdata (sram_rdata)
  );

endmodule

// File: verif/tb_ms_top.sv
// memory stage testbench with directed and random instructions checked against a shadow memory
`timescale 1ns/10ps
`include "ms_macros.svh"

module tb_ms_top;

  localparam int K_ALU   = 0;
  localparam int K_CSR   = 1;
  localparam int K_STORE = 2;
  localparam int K_LOAD  = 3;

  typedef struct packed {
    logic                       gpr_wen;
    logic [`MS_GPR_ADDR_WD-1:0] rd;
    logic [`MS_WORD_WD-1:0]     gpr_result;
    logic                       csr_wen;
    logic [`MS_CSR_ADDR_WD-1:0] csr;
    logic [`MS_WORD_WD-1:0]     csr_result;
  } wb_t;

  logic                       i_clk, i_rst;
  logic                       i_es_valid, i_es_gpr_wen, i_es_csr_wen;
  logic                       i_es_mem_ren, i_es_mem_wen, i_es_csr_inst_sel;
  logic [`MS_GPR_ADDR_WD-1:0] i_es_rd;
  logic [`MS_CSR_ADDR_WD-1:0] i_es_csr;
  ms_pkg::mem_op_e            i_es_mem_op;
  logic [`MS_WORD_WD-1:0]     i_es_csrrdata, i_es_alu_result, i_es_csr_result, i_es_store_data;
  logic                       i_ws_credit;
  logic                       o_es_credit, o_ws_valid, o_ws_gpr_wen, o_ws_csr_wen;
  logic [`MS_GPR_ADDR_WD-1:0] o_ws_rd;
  logic [`MS_CSR_ADDR_WD-1:0] o_ws_csr;
  logic [`MS_WORD_WD-1:0]     o_ws_gpr_result, o_ws_csr_result;

  logic [`MS_WORD_WD-1:0] shadow [`MS_SRAM_DEPTH]; // mirror of the data sram
  wb_t                    exp_q [$];
  int unsigned            pend_q [$];  // cycle at which each write-back slot frees
  int unsigned            ret_delay [1024];
  int unsigned            cyc, ws_count;
  logic                   ws_hold, es_held, credit_seen;

  ms_top UUT (.*);

  always #4 i_clk = ~i_clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      fail_run($sformatf("CHECK FAILED at time %0t: %s got 0x%0h expected 0x%0h",
                         $time, name, got, want));
    end
  endtask

  function automatic logic [63:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [63:0] fill_pattern(input int idx);
    return (64'h9e37_79b9_7f4a_7c15 * 64'(idx + 1)) ^ (64'(idx) << 40);
  endfunction

  // aligned lane bytes from the shadow followed by sign or zero extension
  function automatic logic [63:0] load_value(input logic [63:0] addr, input int op);
    int          nbytes;
    int          base;
    logic [63:0] dw;
    logic [63:0] val;
    nbytes = 1 << (op % 4);
    base   = int'(addr[2:0]) & ~(nbytes - 1);
    dw     = shadow[addr[10:3]];
    val    = '0;
    for (int b = 0; b < nbytes; b++) begin
      val[b*8 +: 8] = dw[(base+b)*8 +: 8];
    end
    if (op < 4 && val[nbytes*8-1]) begin // LB, LH, LW
      for (int i = nbytes * 8; i < 64; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  task automatic store_shadow(input logic [63:0] addr, input logic [63:0] data, input int op);
    int nbytes;
    int base;
    nbytes = 1 << op;
    base   = int'(addr[2:0]) & ~(nbytes - 1);
    for (int b = 0; b < nbytes; b++) begin
      shadow[addr[10:3]][(base+b)*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  // reference model of one write-back result
  function automatic wb_t expected_result(input int op, input logic [63:0] alu);
    wb_t e;
    e.gpr_wen    = i_es_gpr_wen;
    e.rd         = i_es_rd;
    e.csr_wen    = i_es_csr_wen;
    e.csr        = i_es_csr;
    e.csr_result = i_es_csr_result;
    if (i_es_mem_ren) begin
      e.gpr_result = load_value(alu, op);
    end else if (i_es_csr_inst_sel) begin
      e.gpr_result = i_es_csrrdata;
    end else begin
      e.gpr_result = alu;
    end
    return e;
  endfunction

  task automatic next_cycle();
    @(negedge i_clk);
    i_es_valid = 1'b0;
    if (credit_seen) es_held = 1'b1; // usable the cycle after it returns
    credit_seen = (o_es_credit === 1'b1);
  endtask

  task automatic send_instr(input int kind, input logic [63:0] alu, input int op,
                            input logic [63:0] sdata);
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
      assert (n < 100) else fail_run("timeout waiting for the execute credit");
    end while (!es_held);
    i_es_valid        = 1'b1;
    i_es_rd           = `MS_GPR_ADDR_WD'($urandom);
    i_es_csr          = `MS_CSR_ADDR_WD'($urandom);
    i_es_gpr_wen      = 1'($urandom);
    i_es_csr_wen      = 1'($urandom);
    i_es_mem_ren      = (kind == K_LOAD);
    i_es_mem_wen      = (kind == K_STORE);
    i_es_mem_op       = ms_pkg::mem_op_e'(3'(op));
    i_es_csr_inst_sel = (kind == K_CSR) || (kind >= K_STORE && $urandom_range(1, 0) == 1);
    i_es_csrrdata     = rand_word();
    i_es_alu_result   = alu;
    i_es_csr_result   = rand_word();
    i_es_store_data   = sdata;
    exp_q.push_back(expected_result(op, alu));
    if (kind == K_STORE) store_shadow(alu, sdata, op);
    es_held = 1'b0;
  endtask

  task automatic send_and_time(input int kind, input logic [63:0] alu, input int op,
                               input logic [63:0] sdata, input int latency);
    int n;
    send_instr(kind, alu, op, sdata);
    n = 0;
    do begin
      next_cycle();
      n++;
      assert (n < 20) else fail_run("timeout waiting for o_ws_valid");
    end while (o_ws_valid !== 1'b1);
    check_field("o_ws_valid latency", 64'(n), 64'(latency));
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
      assert (n < 400) else fail_run("timeout waiting for the stage to drain");
    end while (exp_q.size() != 0 || pend_q.size() != 0 || !es_held);
    repeat (2) next_cycle(); // last credit reaches the counter
  endtask

  // comparing process and write-back credit model
  always @(negedge i_clk) begin
    wb_t e;
    cyc++;
    if (o_ws_valid === 1'b1) begin
      assert (exp_q.size() > 0) else fail_run("result arrived with nothing outstanding");
      e = exp_q.pop_front();
      check_field("o_ws_gpr_wen", 64'(o_ws_gpr_wen), 64'(e.gpr_wen));
      check_field("o_ws_rd", 64'(o_ws_rd), 64'(e.rd));
      check_field("o_ws_gpr_result", o_ws_gpr_result, e.gpr_result);
      check_field("o_ws_csr_wen", 64'(o_ws_csr_wen), 64'(e.csr_wen));
      check_field("o_ws_csr", 64'(o_ws_csr), 64'(e.csr));
      check_field("o_ws_csr_result", o_ws_csr_result, e.csr_result);
      pend_q.push_back(cyc + 1 + ret_delay[ws_count % 1024]);
      ws_count++;
    end
    i_ws_credit = 1'b0;
    if (!ws_hold && pend_q.size() > 0 && pend_q[0] <= cyc) begin
      void'(pend_q.pop_front());
      i_ws_credit = 1'b1;
    end
  end

  initial begin
    logic [63:0] addr;
    logic [7:0]  idx;
    int unsigned base_cnt;
    int          kind;
    int          op;
    void'($urandom(32'hb604b40c));
    i_clk = 1'b0;
    i_rst = 1'b1;
    {i_es_valid, i_es_gpr_wen, i_es_csr_wen, i_es_mem_ren, i_es_mem_wen} = '0;
    i_es_csr_inst_sel = 1'b0;
    i_es_rd = '0;
    i_es_csr = '0;
    i_es_mem_op = ms_pkg::MEM_LB;
    {i_es_csrrdata, i_es_alu_result, i_es_csr_result, i_es_store_data} = '0;
    i_ws_credit = 1'b0;
    {cyc, ws_count} = '0;
    ws_hold = 1'b0;
    es_held = 1'b1;     // execute starts with its one credit
    credit_seen = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      ret_delay[i] = $urandom_range(6, 0);
    end
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    // quiet outputs after reset and latency of a first non-memory instruction
    repeat (5) begin
      next_cycle();
      check_field("o_ws_valid", 64'(o_ws_valid), 64'd0);
      check_field("o_es_credit", 64'(o_es_credit), 64'd0);
    end
    send_and_time(K_ALU, rand_word(), 0, '0, 1);
    send_and_time(K_CSR, rand_word(), 0, '0, 1);

    // fill every doubleword so loads never see unwritten data
    wait_idle();
    for (int i = 0; i < `MS_SRAM_DEPTH; i++) begin
      addr = rand_word();
      addr[10:0] = {8'(i), 3'b000};
      if (i == 0) send_and_time(K_STORE, addr, 3, fill_pattern(i), 2);
      else send_instr(K_STORE, addr, 3, fill_pattern(i));
    end
    wait_idle();
    send_and_time(K_LOAD, rand_word(), $urandom_range(6, 0), '0, 2);

    // every store width at every offset with all load ops after each
    idx = 8'($urandom);
    for (int sz = 0; sz < 4; sz++) begin
      for (int off = 0; off < 8; off++) begin
        addr = rand_word();
        addr[10:0] = {idx, 3'(off)};
        send_instr(K_STORE, addr, sz, rand_word());
        for (int lop = 0; lop < 7; lop++) begin
          send_instr(K_LOAD, addr, lop, '0);
        end
      end
    end

    // write-back holds its credits so only four results may leave
    // and the stalled fifth one is a load held in RESP
    wait_idle();
    @(posedge i_clk);
    ws_hold = 1'b1;
    base_cnt = ws_count;
    for (int i = 0; i < 5; i++) begin
      send_instr((i + 3) % 4, rand_word(), (i + 3) % 4, rand_word());
    end
    repeat (20) next_cycle();
    check_field("results under back-pressure", 64'(ws_count - base_cnt), 64'd4);
    assert (!es_held && !credit_seen) else fail_run("execute credit came back while stalled");
    @(posedge i_clk);
    ws_hold = 1'b0;
    for (int i = 0; i < 10; i++) begin
      send_instr(i % 4, rand_word(), i % 4, rand_word());
    end
    wait_idle();

    for (int i = 0; i < 400; i++) begin
      kind = $urandom_range(3, 0);
      op = (kind == K_STORE) ? $urandom_range(3, 0) : $urandom_range(6, 0);
      send_instr(kind, rand_word(), op, rand_word());
    end
    wait_idle();

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
design/ms_pkg.sv
design/lsu_load.sv
design/lsu_store.sv
design/data_sram.sv
design/ws_credit_counter.sv
design/ms_ctrl.sv
design/mem_stage.sv
design/ms_top.sv
verif/tb_ms_top.sv

// File: run.sh
#!/bin/sh
# builds the memory stage testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ms_top \
  -f compile.f \
  -o sim_ms_top

./obj_dir/sim_ms_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
grep -q "Done: no errors" sim.log
echo "simulation passed"
